// ==== sim.f ====
verilog/BranchPredPkg.sv
verilog/BranchPredictionTable.sv
verilog/TageIndexHash.sv
verilog/TageTable.sv
verilog/TagePredictor.sv
verilog/GlobalHistory.sv
verilog/TageBranchUnit.sv
sim/TageBranchUnitTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = TageBranchUnitTb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/TageBranchUnitTb.sv ====
module TageBranchUnitTb;
    import BranchPredPkg::*;

    localparam int WATCHDOG_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        predValid;
    BranchAddr_t predAddr;
    logic        predOutValid;
    TagePred_t   predOut;
    logic        updValid;
    TageUpdate_t upd;

    // Expectations for the cycle after a request
    logic    chkTaken, chkAlt, chkId, chkTagged, chkHist;
    logic    expTaken, expAlt;
    TageID_t expId;
    BHist_t  expSnap;
    logic    rstSeen;

    BHist_t      histModel;
    logic [1:0]  baseModel [2**BP_BASEP_ID_LEN];
    TageID_t     provider;
    BranchAddr_t addrA, addrB, addrC, addrD;
    BHist_t      randHist;
    int          valueErrors;
    int          protocolErrors;

    TageBranchUnit TageBranchUnit_inst (
        .clk(clk),
        .rst(rst),
        .predValid(predValid),
        .predAddr(predAddr),
        .predOutValid(predOutValid),
        .predOut(predOut),
        .updValid(updValid),
        .upd(upd)
    );

    always #50 clk = ~clk;

    assert property (@(posedge clk) (rst && rstSeen) |-> !predOutValid)
        else begin
            protocolErrors++;
            $display("Fail %0t predOutValid expected 0 got %0b", $time,
                $sampled(predOutValid));
        end

    assert property (@(posedge clk) disable iff (rst) predOutValid == $past(predValid))
        else begin
            protocolErrors++;
            $display("Fail %0t predOutValid expected %0b got %0b", $time,
                !$sampled(predOutValid), $sampled(predOutValid));
        end

    assert property (@(posedge clk) disable iff (rst) chkTaken |-> predOut.taken == expTaken)
        else begin
            valueErrors++;
            $display("Fail %0t predOut.taken expected %0b got %0b", $time,
                expTaken, $sampled(predOut.taken));
        end

    assert property (@(posedge clk) disable iff (rst) chkAlt |-> predOut.altPred == expAlt)
        else begin
            valueErrors++;
            $display("Fail %0t predOut.altPred expected %0b got %0b", $time,
                expAlt, $sampled(predOut.altPred));
        end

    assert property (@(posedge clk) disable iff (rst) chkId |-> predOut.tageId == expId)
        else begin
            valueErrors++;
            $display("Fail %0t predOut.tageId expected %0d got %0d", $time,
                expId, $sampled(predOut.tageId));
        end

    assert property (@(posedge clk) disable iff (rst) chkTagged |-> predOut.tageId != '0)
        else begin
            valueErrors++;
            $display("Fail %0t predOut.tageId expected a tagged stage got %0d", $time,
                $sampled(predOut.tageId));
        end

    assert property (@(posedge clk) disable iff (rst) chkHist |-> predOut.history == expSnap)
        else begin
            valueErrors++;
            $display("Fail %0t predOut.history expected %h got %h", $time,
                expSnap, $sampled(predOut.history));
        end

    // One request, checked by the assertions one cycle later
    task automatic requestPrediction(input BranchAddr_t addr, input logic cTaken,
                                     input logic eTaken, input logic cAlt, input logic eAlt,
                                     input logic cId, input TageID_t eId, input logic cTagged);
        @(posedge clk);
        predValid <= 1'b1;
        predAddr <= addr;
        @(posedge clk);
        predValid <= 1'b0;
        chkTaken <= cTaken;
        expTaken <= eTaken;
        chkAlt <= cAlt;
        expAlt <= eAlt;
        chkId <= cId;
        expId <= eId;
        chkTagged <= cTagged;
        chkHist <= 1'b1;
        expSnap <= histModel;
        #10;
        provider = predOut.tageId;
        @(posedge clk);
        {chkTaken, chkAlt, chkId, chkTagged, chkHist} <= '0;
        histModel = {histModel[62:0], cTaken ? eTaken : predOut.taken};
    endtask

    task automatic sendUpdate(input BranchAddr_t addr, input BHist_t hist, input TageID_t id,
                              input logic taken, input logic alt, input logic predicted);
        TageUpdate_t rec;
        rec.addr = addr;
        rec.history = hist;
        rec.tageId = id;
        rec.taken = taken;
        rec.altPred = alt;
        rec.pred = predicted;
        @(posedge clk);
        updValid <= 1'b1;
        upd <= rec;
        @(posedge clk);
        updValid <= 1'b0;
        if (id == '0) begin
            if (taken && baseModel[addr[7:0]] != 2'b11)
                baseModel[addr[7:0]]++;
            else if (!taken && baseModel[addr[7:0]] != 2'b00)
                baseModel[addr[7:0]]--;
        end
        if (taken != predicted) begin
            histModel = {hist[62:0], taken};
        end
    endtask

    // Stage ID 3 lies past the last stage, so only the history is repaired
    task automatic repairHistory(input BranchAddr_t addr, input BHist_t hist, input logic taken);
        sendUpdate(addr, hist, 2'd3, taken, !taken, !taken);
    endtask

    initial begin
        @(negedge rst);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(75));
        clk = 1'b0;
        rst = 1'b1;
        predValid = 1'b0;
        predAddr = '0;
        updValid = 1'b0;
        upd = '0;
        {chkTaken, chkAlt, chkId, chkTagged, chkHist} = '0;
        {expTaken, expAlt, expId, expSnap} = '0;
        rstSeen = 1'b0;
        histModel = '0;
        provider = '0;
        valueErrors = 0;
        protocolErrors = 0;
        for (int i = 0; i < 2**BP_BASEP_ID_LEN; i++) begin
            baseModel[i] = 2'b01;
        end

        // Distinct base indices keep the addresses independent
        addrA = BranchAddr_t'($urandom);
        addrB = BranchAddr_t'($urandom);
        while (addrB[7:0] == addrA[7:0])
            addrB = BranchAddr_t'($urandom);
        addrC = BranchAddr_t'($urandom);
        while (addrC[7:0] == addrA[7:0] || addrC[7:0] == addrB[7:0])
            addrC = BranchAddr_t'($urandom);
        addrD = BranchAddr_t'($urandom);
        randHist = {$urandom, $urandom};

        @(posedge clk);
        rstSeen <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (300) @(posedge clk);

        // Fresh address
        requestPrediction(addrC, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0, 1'b0);

        // Base training without a mispredict
        sendUpdate(addrB, histModel, 2'd0, 1'b1, 1'b1, 1'b1);
        sendUpdate(addrB, histModel, 2'd0, 1'b1, 1'b1, 1'b1);
        requestPrediction(addrB, 1'b1, baseModel[addrB[7:0]][1], 1'b1,
            baseModel[addrB[7:0]][1], 1'b1, 2'd0, 1'b0);
        requestPrediction(addrB, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 2'd0, 1'b0);

        // All ones history survives a taken repair and taken predictions
        repairHistory(addrC, '1, 1'b1);
        sendUpdate(addrA, '1, 2'd0, 1'b1, 1'b0, 1'b0);
        requestPrediction(addrA, 1'b1, 1'b1, 1'b1, baseModel[addrA[7:0]][1], 1'b0, 2'd0, 1'b1);

        // Weak counter flips after one opposite update
        sendUpdate(addrA, '1, provider, 1'b0, 1'b0, 1'b0);
        requestPrediction(addrA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);
        repairHistory(addrC, '1, 1'b1);
        sendUpdate(addrA, '1, provider, 1'b0, 1'b0, 1'b0);
        requestPrediction(addrA, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);

        // Snapshot after a repair with an arbitrary history
        repairHistory(addrC, randHist, randHist[0]);
        requestPrediction(addrD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);

        repeat (3) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/TageBranchUnit.sv ====
module TageBranchUnit #(
    parameter int NUM_STAGES = 3,
    parameter int FACTOR     = 2,
    parameter int BASE       = 6,
    parameter int TABLE_SIZE = 64,
    parameter int TAG_SIZE   = 9
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        predValid,
    input  BranchPredPkg::BranchAddr_t  predAddr,
    output logic                        predOutValid,
    output BranchPredPkg::TagePred_t    predOut,

    input  logic                        updValid,
    input  BranchPredPkg::TageUpdate_t  upd
);
    import BranchPredPkg::*;

    BHist_t curHistory;
    logic   repair;

    assign repair = updValid && (upd.taken != upd.pred);

    GlobalHistory gHist (
        .clk(clk),
        .rst(rst),
        .predOutValid(predOutValid),
        .predTaken(predOut.taken),
        .repair(repair),
        .repairHistory(upd.history),
        .repairTaken(upd.taken),
        .history(curHistory)
    );

    TagePredictor #(
        .NUM_STAGES(NUM_STAGES),
        .FACTOR(FACTOR),
        .BASE(BASE),
        .TABLE_SIZE(TABLE_SIZE),
        .TAG_SIZE(TAG_SIZE)
    ) predictor (
        .clk(clk),
        .rst(rst),
        .predValid(predValid),
        .predAddr(predAddr),
        .predHistory(curHistory),
        .pred(predOut),
        .predOutValid(predOutValid),
        .updValid(updValid),
        .upd(upd)
    );

endmodule

// ==== verilog/GlobalHistory.sv ====
module GlobalHistory (
    input  logic                  clk,
    input  logic                  rst,

    // Prediction leaving the predictor this cycle
    input  logic                  predOutValid,
    input  logic                  predTaken,

    // Mispredict repair
    input  logic                  repair,
    input  BranchPredPkg::BHist_t repairHistory,
    input  logic                  repairTaken,

    output BranchPredPkg::BHist_t history
);
    import BranchPredPkg::*;

    BHist_t histReg;
    BHist_t nextHist;

    // Repair wins over the speculative shift
    always_comb begin
        nextHist = histReg;
        if (repair) begin
            nextHist = {repairHistory[$bits(BHist_t)-2:0], repairTaken};
        end else if (predOutValid) begin
            nextHist = {histReg[$bits(BHist_t)-2:0], predTaken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            histReg <= '0;
        end else begin
            histReg <= nextHist;
        end
    end

    // A request in the same cycle as a returning prediction
    // already hashes with that branch's direction
    assign history = nextHist;

    // Predictor output stays quiet while the history restarts from zero
    assert property (@(posedge clk)
        rst |=> (histReg == '0) && !predOutValid);

endmodule

// ==== verilog/TagePredictor.sv ====
module TagePredictor #(
    parameter int NUM_STAGES = 3,
    parameter int FACTOR     = 2,
    parameter int BASE       = 6,
    parameter int TABLE_SIZE = 64,
    parameter int TAG_SIZE   = 9
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        predValid,
    input  BranchPredPkg::BranchAddr_t  predAddr,
    input  BranchPredPkg::BHist_t       predHistory,
    output BranchPredPkg::TagePred_t    pred,
    output logic                        predOutValid,

    input  logic                        updValid,
    input  BranchPredPkg::TageUpdate_t  upd
);
    import BranchPredPkg::*;

    localparam int HASH_SIZE = $clog2(TABLE_SIZE);

    logic [NUM_STAGES-1:1] hits;
    logic [NUM_STAGES-1:0] dirs;
    logic [NUM_STAGES-1:1] avail;
    logic [NUM_STAGES-1:1] doAlloc;
    logic                  allocFailed;
    logic [7:0]            lfsr;
    BHist_t                histQ;

    BranchPredictionTable #(
        .IDX_LEN(BP_BASEP_ID_LEN)
    ) baseTable (
        .clk(clk),
        .rst(rst),
        .readValid(predValid),
        .readAddr(predAddr[BP_BASEP_ID_LEN-1:0]),
        .taken(dirs[0]),
        .writeEn(updValid && upd.tageId == '0),
        .writeAddr(upd.addr[BP_BASEP_ID_LEN-1:0]),
        .writeTaken(upd.taken)
    );

    generate
        for (genvar s = 1; s < NUM_STAGES; s++) begin : gStage
            localparam int HIST_LEN = BASE * (FACTOR ** s);

            logic [HASH_SIZE-1:0] predIdx;
            logic [HASH_SIZE-1:0] updIdx;
            logic [TAG_SIZE-1:0]  predTag;
            logic [TAG_SIZE-1:0]  updTag;

            TageIndexHash #(
                .HIST_LEN(HIST_LEN),
                .HASH_SIZE(HASH_SIZE),
                .TAG_SIZE(TAG_SIZE)
            ) predHash (
                .addr(predAddr),
                .history(predHistory),
                .index(predIdx),
                .tag(predTag)
            );

            TageIndexHash #(
                .HIST_LEN(HIST_LEN),
                .HASH_SIZE(HASH_SIZE),
                .TAG_SIZE(TAG_SIZE)
            ) updHash (
                .addr(upd.addr),
                .history(upd.history),
                .index(updIdx),
                .tag(updTag)
            );

            TageTable #(
                .SIZE(TABLE_SIZE),
                .TAG_SIZE(TAG_SIZE)
            ) tagTable (
                .clk(clk),
                .rst(rst),
                .readValid(predValid),
                .readAddr(predIdx),
                .readTag(predTag),
                .hit(hits[s]),
                .readTaken(dirs[s]),
                .writeValid(updValid),
                .writeAddr(updIdx),
                .writeTag(updTag),
                .writeTaken(upd.taken),
                .writeUpdate(upd.tageId == TageID_t'(s)),
                .writeUseful(upd.pred != upd.altPred),
                .writeCorrect(upd.pred == upd.taken),
                .allocAvail(avail[s]),
                .doAlloc(doAlloc[s]),
                .allocFailed(allocFailed && TageID_t'(s) > upd.tageId)
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'd1;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // Pick one longer-history stage on a mispredict
    always_comb begin
        logic                  found;
        logic [NUM_STAGES-1:1] laterAvail;

        found = 1'b0;
        laterAvail = '0;
        doAlloc = '0;
        allocFailed = 1'b0;

        for (int i = 1; i < NUM_STAGES; i++) begin
            for (int j = i + 1; j < NUM_STAGES; j++) begin
                laterAvail[i] = laterAvail[i] | avail[j];
            end
        end

        if (updValid && upd.taken != upd.pred) begin
            for (int i = 1; i < NUM_STAGES; i++) begin
                // 75% chance to take a stage when a longer one is free too
                if (i > int'(upd.tageId) && avail[i] && !found &&
                    (!laterAvail[i] || lfsr[2*i-2 +: 2] != 2'b00)) begin
                    found = 1'b1;
                    doAlloc[i] = 1'b1;
                end
            end
            allocFailed = !found;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predOutValid <= 1'b0;
        end else begin
            predOutValid <= predValid;
        end
    end

    // History snapshot travels with the table reads
    always_ff @(posedge clk) begin
        if (predValid) begin
            histQ <= predHistory;
        end
    end

    // Longest hitting stage provides, next lower one is the alternate
    always_comb begin
        pred.taken = dirs[0];
        pred.altPred = dirs[0];
        pred.tageId = '0;
        pred.history = histQ;
        for (int i = 1; i < NUM_STAGES; i++) begin
            if (hits[i]) begin
                pred.altPred = pred.taken;
                pred.taken = dirs[i];
                pred.tageId = TageID_t'(i);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0(doAlloc) && (doAlloc == '0 || (updValid && upd.taken != upd.pred)));

endmodule

// ==== verilog/TageTable.sv ====
module TageTable #(
    parameter int SIZE     = 64,
    parameter int TAG_SIZE = 9
) (
    input  logic                     clk,
    input  logic                     rst,

    // Lookup
    input  logic                     readValid,
    input  logic [$clog2(SIZE)-1:0]  readAddr,
    input  logic [TAG_SIZE-1:0]      readTag,
    output logic                     hit,
    output logic                     readTaken,

    // Resolved branch
    input  logic                     writeValid,
    input  logic [$clog2(SIZE)-1:0]  writeAddr,
    input  logic [TAG_SIZE-1:0]      writeTag,
    input  logic                     writeTaken,

    // Provider training
    input  logic                     writeUpdate,
    input  logic                     writeUseful,
    input  logic                     writeCorrect,

    // Allocation
    output logic                     allocAvail,
    input  logic                     doAlloc,
    input  logic                     allocFailed
);
    import BranchPredPkg::*;

    logic [TAG_SIZE-1:0] entryTag [SIZE];
    TageCtr_t            entryCtr [SIZE];
    logic [SIZE-1:0]     entryValid;
    UsefulCtr_t [SIZE-1:0] entryUseful;

    TageCtr_t   curCtr;
    UsefulCtr_t curUseful;

    assign curCtr = entryCtr[writeAddr];
    assign curUseful = entryUseful[writeAddr];

    // Only entries nobody finds useful may be replaced
    assign allocAvail = (curUseful == '0);

    always_ff @(posedge clk) begin
        if (readValid) begin
            hit <= entryValid[readAddr] && (entryTag[readAddr] == readTag);
            readTaken <= entryCtr[readAddr][2];
        end
    end

    // Tag and direction counter
    always_ff @(posedge clk) begin
        if (writeValid) begin
            if (doAlloc) begin
                entryTag[writeAddr] <= writeTag;
                entryCtr[writeAddr] <= writeTaken ? CTR_INIT_TAKEN : CTR_INIT_NOT_TAKEN;
            end else if (writeUpdate) begin
                if (writeTaken && curCtr != 3'b111) begin
                    entryCtr[writeAddr] <= curCtr + 3'd1;
                end else if (!writeTaken && curCtr != 3'b000) begin
                    entryCtr[writeAddr] <= curCtr - 3'd1;
                end
            end
        end
    end

    // Valid bit and usefulness
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            entryUseful <= '0;
        end else if (writeValid) begin
            if (doAlloc) begin
                entryValid[writeAddr] <= 1'b1;
                entryUseful[writeAddr] <= '0;
            end else if (writeUpdate && writeUseful) begin
                if (writeCorrect && curUseful != 2'b11) begin
                    entryUseful[writeAddr] <= curUseful + 2'd1;
                end else if (!writeCorrect && curUseful != 2'b00) begin
                    entryUseful[writeAddr] <= curUseful - 2'd1;
                end
            end else if (allocFailed && curUseful != 2'b00) begin
                // Decay so a later mispredict finds room
                entryUseful[writeAddr] <= curUseful - 2'd1;
            end
        end
    end

    // Allocation choice in the predictor must respect this table's usefulness
    assert property (@(posedge clk) disable iff (rst)
        (writeValid && doAlloc) |-> allocAvail);

endmodule

// ==== verilog/TageIndexHash.sv ====
module TageIndexHash #(
    parameter int HIST_LEN  = 12,
    parameter int HASH_SIZE = 6,
    parameter int TAG_SIZE  = 9
) (
    input  BranchPredPkg::BranchAddr_t addr,
    input  BranchPredPkg::BHist_t      history,
    output logic [HASH_SIZE-1:0]       index,
    output logic [TAG_SIZE-1:0]        tag
);
    import BranchPredPkg::*;

    // Whole address slices folded into the index
    localparam int NUM_SLICES = $bits(BranchAddr_t) / HASH_SIZE;

    always_comb begin
        index = '0;
        for (int i = 0; i < NUM_SLICES; i++) begin
            index = index ^ addr[i*HASH_SIZE +: HASH_SIZE];
        end

        tag = addr[TAG_SIZE-1:0];

        // History folded onto index and tag
        // tag mixes neighbouring bits so it differs from the index fold
        for (int j = 0; j < HIST_LEN; j++) begin
            index[j % HASH_SIZE] = index[j % HASH_SIZE] ^ history[j];
            tag[j % TAG_SIZE] = tag[j % TAG_SIZE] ^ history[j] ^ history[j+1];
        end
    end

endmodule

// ==== verilog/BranchPredictionTable.sv ====
module BranchPredictionTable #(
    parameter int IDX_LEN = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               readValid,
    input  logic [IDX_LEN-1:0] readAddr,
    output logic               taken,

    input  logic               writeEn,
    input  logic [IDX_LEN-1:0] writeAddr,
    input  logic               writeTaken
);
    import BranchPredPkg::*;

    BaseCtr_t counters [2**IDX_LEN];

    logic [IDX_LEN-1:0] walkIdx;
    logic               walking;
    BaseCtr_t           curCtr;

    // Init walk sets every counter to weakly not taken
    always_ff @(posedge clk) begin
        if (rst) begin
            walking <= 1'b1;
            walkIdx <= '0;
        end else if (walking) begin
            walkIdx <= walkIdx + 1'b1;
            if (walkIdx == '1) begin
                walking <= 1'b0;
            end
        end
    end

    assign curCtr = counters[writeAddr];

    always_ff @(posedge clk) begin
        if (walking) begin
            counters[walkIdx] <= 2'b01;
        end else if (writeEn) begin
            if (writeTaken && curCtr != 2'b11) begin
                counters[writeAddr] <= curCtr + 2'd1;
            end else if (!writeTaken && curCtr != 2'b00) begin
                counters[writeAddr] <= curCtr - 2'd1;
            end
        end
    end

    // Read sees the contents before a same-cycle write
    always_ff @(posedge clk) begin
        if (readValid) begin
            taken <= counters[readAddr][1];
        end
    end

endmodule

// ==== verilog/BranchPredPkg.sv ====
package BranchPredPkg;

    // Global history, youngest outcome in bit 0
    typedef logic [63:0] BHist_t;

    // Providing stage, 0 is the bimodal base table
    typedef logic [1:0] TageID_t;

    // Branch address without its lowest bit
    typedef logic [30:0] BranchAddr_t;

    // Counter types
    typedef logic [1:0] BaseCtr_t;
    typedef logic [2:0] TageCtr_t;
    typedef logic [1:0] UsefulCtr_t;

    // Base table index width
    localparam int BP_BASEP_ID_LEN = 8;

    // Initial values of a freshly allocated tagged counter (weak)
    localparam TageCtr_t CTR_INIT_TAKEN = 3'd4;
    localparam TageCtr_t CTR_INIT_NOT_TAKEN = 3'd3;

    // One prediction as returned to the core
    typedef struct packed {
        TageID_t tageId;
        logic    altPred;
        logic    taken;
        BHist_t  history;
    } TagePred_t;

    // One resolved branch as returned by the core
    typedef struct packed {
        BranchAddr_t addr;
        BHist_t      history;
        TageID_t     tageId;
        logic        taken;
        logic        altPred;
        logic        pred;
    } TageUpdate_t;

endpackage
